// File: sens_io_top.f
src/sens_io_pkg.sv
src/cmd_deser.sv
src/sens_ctrl_regs.sv
src/sens_test_pattern.sv
src/sens_status_mon.sv
src/sens_io_top.sv
dv/tb_sens_io.sv

// File: dv/tb_sens_io.sv
/*
 * Self-checking testbench for the sensor front-end port. A table of
 * commands, optional frames and expected pin/status values is applied
 * in order; pixels are checked against a gradient model on every
 * valid cycle. A watchdog bounds the run.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_sens_io;

    localparam int NUM_TESTS = 14;
    localparam int W_INC     = 3;       // pixels per col8 step
    localparam int H_INC     = 3;       // lines per row8 step
    localparam int LINES     = 4;
    localparam int PIXELS    = 8;       // valid pixels per line
    localparam int HBLANK    = 3;       // idle cycles between lines

    logic        pclk = 1'b0;
    logic        rst;
    logic [7:0]  cmd_ad_i;
    logic        cmd_stb_i;
    logic [15:0] pxd_i;
    logic        dvalid_i;
    logic        hsync_i;
    logic        vsync_i;
    logic        perr_i;
    logic [3:0]  gp_i;
    logic [15:0] pxd_o;
    logic        dvalid_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        sens_mrst_o;
    logic [3:0]  gp_oe_o;
    logic [3:0]  gp_out_o;
    logic [15:0] status_o;

    // test table
    string       t_name   [NUM_TESTS];
    logic [15:0] t_addr   [NUM_TESTS];
    logic [31:0] t_data   [NUM_TESTS];
    int          t_pmode  [NUM_TESTS];  // pixel rule, -1 means no frame
    int          t_perr   [NUM_TESTS];  // perr cycles in the frame
    logic [3:0]  t_gpin   [NUM_TESTS];
    logic [3:0]  t_oe     [NUM_TESTS];
    logic [3:0]  t_out    [NUM_TESTS];
    logic        t_mrst   [NUM_TESTS];
    logic [15:0] t_status [NUM_TESTS];

    int     n_entries = 0;
    int     test_errs;
    int     pass_cnt  = 0;
    int     fail_cnt  = 0;
    integer seed      = 32'he27db697;

    always #5 pclk = ~pclk;            // 10 ns period

    sens_io_top #(
        .SENSIO_ADDR      (16'h0330),
        .SENSIO_ADDR_MASK (16'h07f8),
        .TEST_WIDTH_INC   (W_INC),
        .TEST_HEIGHT_INC  (H_INC)
    ) i_dut (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (rst),
        .cmd_ad_i                  (cmd_ad_i),
        .cmd_stb_i                 (cmd_stb_i),
        .pxd_i                     (pxd_i),
        .dvalid_i                  (dvalid_i),
        .hsync_i                   (hsync_i),
        .vsync_i                   (vsync_i),
        .perr_i                    (perr_i),
        .gp_i                      (gp_i),
        .pxd_o                     (pxd_o),
        .dvalid_o                  (dvalid_o),
        .hsync_o                   (hsync_o),
        .vsync_o                   (vsync_o),
        .sens_mrst_o               (sens_mrst_o),
        .gp_oe_o                   (gp_oe_o),
        .gp_out_o                  (gp_out_o),
        .status_o                  (status_o)
    );

    task automatic set_entry(input string name, input logic [15:0] addr,
                             input logic [31:0] data, input int pmode, input int perr_n,
                             input logic [3:0] gpin, input logic [3:0] oe,
                             input logic [3:0] out, input logic mrst, input logic [15:0] st);
        t_name[n_entries]   = name;
        t_addr[n_entries]   = addr;
        t_data[n_entries]   = data;
        t_pmode[n_entries]  = pmode;
        t_perr[n_entries]   = perr_n;
        t_gpin[n_entries]   = gpin;
        t_oe[n_entries]     = oe;
        t_out[n_entries]    = out;
        t_mrst[n_entries]   = mrst;
        t_status[n_entries] = st;
        n_entries++;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch %0s: expected %h, actual %h", what, exp_v, act_v);
            test_errs++;
        end
    endtask

    // expected pixel from line/column position
    function automatic logic [15:0] grad_pixel(input int mode, input int line, input int col,
                                               input logic [15:0] raw);
        logic [15:0] pix;
        case (mode)
            0:       pix = raw;                                 // pass through
            1:       pix = {8'(line / H_INC), 8'(col / W_INC)};
            2:       pix = 16'(col);
            default: pix = 16'(line);
        endcase
        return pix;
    endfunction

    // six bytes, strobe with the first, then settle time
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] cmd_bits;
        cmd_bits = {data, addr};        // AL first, D3 last
        for (int i = 0; i < 6; i++) begin
            @(negedge pclk);
            cmd_stb_i = (i == 0);
            cmd_ad_i  = cmd_bits[i*8 +: 8];
        end
        @(negedge pclk);
        cmd_stb_i = 1'b0;
        cmd_ad_i  = 8'h00;
        repeat (12) @(negedge pclk);
    endtask

    // one frame, perr on the first perr_n valid pixels
    task automatic run_frame(input string name, input int mode, input int perr_n);
        int          pix_idx;
        logic [15:0] raw;
        pix_idx = 0;
        @(negedge pclk);
        vsync_i = 1'b1;
        @(negedge pclk);                // one blank cycle inside vsync
        for (int line = 0; line < LINES; line++) begin
            for (int col = 0; col < PIXELS; col++) begin
                raw      = 16'($random(seed));
                pxd_i    = raw;
                dvalid_i = 1'b1;
                hsync_i  = 1'b1;
                perr_i   = (pix_idx < perr_n);
                #1;                     // combinational path settles
                check_value({name, " pxd_o"}, 32'(grad_pixel(mode, line, col, raw)),
                            32'(pxd_o));
                check_value({name, " syncs"}, 32'h7, {29'd0, hsync_o, vsync_o, dvalid_o});
                pix_idx++;
                @(negedge pclk);
            end
            dvalid_i = 1'b0;
            hsync_i  = 1'b0;
            perr_i   = 1'b0;
            pxd_i    = 16'h0000;
            #1;                         // blank cycle, only vsync high
            check_value({name, " syncs"}, 32'h2, {29'd0, hsync_o, vsync_o, dvalid_o});
            repeat (HBLANK) @(negedge pclk);
        end
        vsync_i = 1'b0;
        repeat (2) @(negedge pclk);
    endtask

    initial begin
        rst       = 1'b1;
        cmd_ad_i  = 8'h00;
        cmd_stb_i = 1'b0;
        pxd_i     = 16'h0000;
        dvalid_i  = 1'b0;
        hsync_i   = 1'b0;
        vsync_i   = 1'b0;
        perr_i    = 1'b0;
        gp_i      = 4'h0;

        // name, addr, data, pix mode, perr, gp_i, gp_oe, gp_out, mrst, status
        set_entry("gp_set",       16'h0330, 32'h007f5000, -1, 0, 4'h5, 4'h7, 4'h6, 0, 16'h5000);
        set_entry("out_of_window",16'h0338, 32'h3fffffff, -1, 0, 4'ha, 4'h7, 4'h6, 0, 16'ha000);
        set_entry("gp_mask_hi",   16'h8330, 32'h00a04000, -1, 0, 4'h3, 4'he, 4'h6, 0, 16'h3000);
        set_entry("mrst_on",      16'h0330, 32'h00000003, -1, 0, 4'hc, 4'he, 4'h6, 1, 16'hc400);
        set_entry("mrst_off",     16'h0330, 32'h00000002, -1, 0, 4'h0, 4'he, 4'h6, 0, 16'h0000);
        set_entry("pass_frame",   16'h0330, 32'h23000000,  0, 5, 4'h1, 4'he, 4'h6, 0, 16'h1305);
        set_entry("clr_perr",     16'h0330, 32'h00000000, -1, 0, 4'h2, 4'he, 4'h6, 0, 16'h2205);
        set_entry("clr_hact",     16'h0331, 32'h00000000, -1, 0, 4'h0, 4'he, 4'h6, 0, 16'h0005);
        set_entry("grad_mode1",   16'h0330, 32'h24000000,  1, 0, 4'h4, 4'he, 4'h6, 0, 16'h4a05);
        set_entry("grad_mode2",   16'h0330, 32'h28000000,  2, 2, 4'h7, 4'he, 4'h6, 0, 16'h7b07);
        set_entry("grad_mode3",   16'h0330, 32'h2c000000,  3, 0, 4'h8, 4'he, 4'h6, 0, 16'h8a07);
        set_entry("grad_mode7",   16'h0330, 32'h3c000000,  7, 0, 4'hf, 4'he, 4'h6, 0, 16'hfa07);
        set_entry("alt_off_pass", 16'h0330, 32'h22000000,  0, 1, 4'h6, 4'he, 4'h6, 0, 16'h6300);
        set_entry("alt_on_count", 16'h0330, 32'h03000000, -1, 0, 4'h9, 4'he, 4'h6, 0, 16'h9208);

        repeat (2) @(posedge pclk);     // reset held two cycles
        @(negedge pclk);
        rst = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errs = 0;
            @(negedge pclk);
            gp_i = t_gpin[t];
            send_cmd(t_addr[t], t_data[t]);
            if (t_pmode[t] >= 0) begin
                run_frame(t_name[t], t_pmode[t], t_perr[t]);
            end
            repeat (2) @(negedge pclk);
            check_value({t_name[t], " gp_oe_o"}, 32'(t_oe[t]), 32'(gp_oe_o));
            check_value({t_name[t], " gp_out_o"}, 32'(t_out[t]), 32'(gp_out_o));
            check_value({t_name[t], " sens_mrst_o"}, 32'(t_mrst[t]), 32'(sens_mrst_o));
            check_value({t_name[t], " status_o"}, 32'(t_status[t]), 32'(status_o));
            if (test_errs == 0) begin
                pass_cnt++;
                $display("test %0s passed", t_name[t]);
            end else begin
                fail_cnt++;
                $display("test %0s failed with %0d errors", t_name[t], test_errs);
            end
        end

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // about 80 cycles per entry are needed, allow 200
    initial begin
        repeat (NUM_TESTS * 200) @(posedge pclk);
        $display("run timed out after %0d cycles", NUM_TESTS * 200);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/sens_io_top.sv
/*
 * Sensor front-end port, slow-control and pixel side. Connects the command
 * receiver, control registers, test pattern generator and status monitor,
 * all on pclk. Sync signals pass straight through to the outputs.
 */
`timescale 1ns/1ns
`default_nettype none

module sens_io_top #(
    parameter logic [15:0] SENSIO_ADDR      = 16'h330,
    parameter logic [15:0] SENSIO_ADDR_MASK = 16'h7f8,
    parameter int unsigned TEST_WIDTH_INC   = 3,
    parameter int unsigned TEST_HEIGHT_INC  = 3
) (
    input  wire logic               pclk,
    input  wire logic               async_prst_with_sens_mrst,
    input  wire logic [7:0]         cmd_ad_i,
    input  wire logic               cmd_stb_i,
    input  wire sens_io_pkg::pix_t  pxd_i,
    input  wire logic               dvalid_i,
    input  wire logic               hsync_i,
    input  wire logic               vsync_i,
    input  wire logic               perr_i,
    input  wire logic [3:0]         gp_i,
    output sens_io_pkg::pix_t       pxd_o,
    output logic                    dvalid_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    sens_mrst_o,
    output logic [3:0]              gp_oe_o,
    output logic [3:0]              gp_out_o,
    output sens_io_pkg::status_t    status_o
);
    import sens_io_pkg::*;

    logic       cmd_we;
    cmd_addr_t  cmd_a;
    cmd_data_t  cmd_data;
    test_mode_t test_mode;
    logic       alt_status;
    logic       imrst;
    logic       clr_perr;
    logic       clr_hact;

    assign dvalid_o    = dvalid_i;      // syncs unchanged
    assign hsync_o     = hsync_i;
    assign vsync_o     = vsync_i;
    assign sens_mrst_o = imrst;

    cmd_deser #(
        .SENSIO_ADDR      (SENSIO_ADDR),
        .SENSIO_ADDR_MASK (SENSIO_ADDR_MASK)
    ) i_cmd_deser (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_ad_i                  (cmd_ad_i),
        .cmd_stb_i                 (cmd_stb_i),
        .cmd_a_o                   (cmd_a),
        .cmd_data_o                (cmd_data),
        .cmd_we_o                  (cmd_we)
    );

    sens_ctrl_regs i_ctrl_regs (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_we_i                  (cmd_we),
        .cmd_a_i                   (cmd_a),
        .cmd_data_i                (cmd_data),
        .imrst_o                   (imrst),
        .gp_oe_o                   (gp_oe_o),
        .gp_out_o                  (gp_out_o),
        .alt_status_o              (alt_status),
        .test_mode_o               (test_mode),
        .clr_perr_o                (clr_perr),
        .clr_hact_o                (clr_hact)
    );

    sens_test_pattern #(
        .TEST_WIDTH_INC  (TEST_WIDTH_INC),
        .TEST_HEIGHT_INC (TEST_HEIGHT_INC)
    ) i_test_pattern (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .test_mode_i               (test_mode),
        .pxd_i                     (pxd_i),
        .dvalid_i                  (dvalid_i),
        .vsync_i                   (vsync_i),
        .pxd_o                     (pxd_o)
    );

    sens_status_mon i_status_mon (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .perr_i                    (perr_i),
        .dvalid_i                  (dvalid_i),
        .clr_perr_i                (clr_perr),
        .clr_hact_i                (clr_hact),
        .alt_status_i              (alt_status),
        .imrst_i                   (imrst),
        .test_active_i             (|test_mode),    // any gradient mode
        .gp_i                      (gp_i),
        .status_o                  (status_o)
    );

endmodule

`default_nettype wire

// File: src/sens_status_mon.sv
/*
 * Status monitor. Counts parity errors, keeps sticky perr and line-activity
 * flags and registers the parallel status word, so status_o shows an
 * event on the cycle after it happened.
 */
`timescale 1ns/1ns
`default_nettype none

module sens_status_mon (
    input  wire logic           pclk,
    input  wire logic           async_prst_with_sens_mrst,
    input  wire logic           perr_i,
    input  wire logic           dvalid_i,
    input  wire logic           clr_perr_i,
    input  wire logic           clr_hact_i,
    input  wire logic           alt_status_i,
    input  wire logic           imrst_i,
    input  wire logic           test_active_i,
    input  wire logic [3:0]     gp_i,
    output sens_io_pkg::status_t status_o
);
    import sens_io_pkg::*;

    logic [7:0] perr_cntr_q;
    logic [7:0] perr_cntr_d;
    logic       perr_sticky_q;
    logic       perr_sticky_d;
    logic       hact_alive_q;
    logic       hact_alive_d;
    logic       dvalid_q;
    status_t    status_d;

    always_comb begin
        perr_cntr_d   = perr_cntr_q + 8'(perr_i);                    // wraps at 256
        perr_sticky_d = perr_i || (perr_sticky_q && !clr_perr_i);    // new error beats clear
        hact_alive_d  = (dvalid_i && !dvalid_q) || (hact_alive_q && !clr_hact_i);

        status_d                    = '0;
        status_d[ST_BYTE +: 8]      = alt_status_i ? perr_cntr_d : 8'h00;
        status_d[ST_PERR_STICKY]    = perr_sticky_d;
        status_d[ST_HACT_ALIVE]     = hact_alive_d;
        status_d[ST_SENS_MRST]      = imrst_i;
        status_d[ST_TEST_ACTIVE]    = test_active_i;
        status_d[ST_GP_IN +: 4]     = gp_i;     // pin readback
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            dvalid_q      <= 1'b0;
            perr_cntr_q   <= '0;                // only reset clears the count
            perr_sticky_q <= 1'b0;
            hact_alive_q  <= 1'b0;
            status_o      <= '0;
        end else begin
            dvalid_q      <= dvalid_i;
            perr_cntr_q   <= perr_cntr_d;
            perr_sticky_q <= perr_sticky_d;
            hact_alive_q  <= hact_alive_d;
            status_o      <= status_d;
        end
    end

    a_perr_sticky: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        perr_i |=> (perr_sticky_q && status_o[ST_PERR_STICKY]));

endmodule

`default_nettype wire

// File: src/sens_test_pattern.sv
/*
 * Test gradient generator. Tracks column and row position of the incoming
 * frame from dvalid and vsync and, when test mode is nonzero, replaces
 * the pixel data with a row/column gradient. The pixel path is combinational.
 */
`timescale 1ns/1ns
`default_nettype none

module sens_test_pattern #(
    parameter int unsigned TEST_WIDTH_INC  = 3,
    parameter int unsigned TEST_HEIGHT_INC = 3
) (
    input  wire logic                   pclk,
    input  wire logic                   async_prst_with_sens_mrst,
    input  wire sens_io_pkg::test_mode_t test_mode_i,
    input  wire sens_io_pkg::pix_t      pxd_i,
    input  wire logic                   dvalid_i,
    input  wire logic                   vsync_i,
    output sens_io_pkg::pix_t           pxd_o
);
    import sens_io_pkg::*;

    localparam int unsigned CDIV_W = $clog2(TEST_WIDTH_INC + 1);
    localparam int unsigned RDIV_W = $clog2(TEST_HEIGHT_INC + 1);

    logic [COL_BITS-1:0] col_q;
    logic [ROW_BITS-1:0] row_q;
    logic [7:0]          col8_q;
    logic [7:0]          row8_q;
    logic [CDIV_W-1:0]   col_div_q;     // counts down pixels per col8 step
    logic [RDIV_W-1:0]   row_div_q;     // counts down lines per row8 step
    logic                dvalid_q;
    logic                line_end;

    assign line_end = dvalid_q && !dvalid_i;   // falling edge of dvalid

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            dvalid_q  <= 1'b0;
            col_q     <= '0;
            col8_q    <= '0;
            col_div_q <= CDIV_W'(TEST_WIDTH_INC - 1);
            row_q     <= '0;
            row8_q    <= '0;
            row_div_q <= RDIV_W'(TEST_HEIGHT_INC - 1);
        end else begin
            dvalid_q <= dvalid_i;

            if (!dvalid_i || !vsync_i) begin        // column counts restart each line
                col_q     <= '0;
                col8_q    <= '0;
                col_div_q <= CDIV_W'(TEST_WIDTH_INC - 1);
            end else begin
                col_q <= col_q + 1'b1;
                if (col_div_q == '0) begin
                    col_div_q <= CDIV_W'(TEST_WIDTH_INC - 1);
                    col8_q    <= col8_q + 1'b1;
                end else begin
                    col_div_q <= col_div_q - 1'b1;
                end
            end

            if (!vsync_i) begin                     // row counts restart each frame
                row_q     <= '0;
                row8_q    <= '0;
                row_div_q <= RDIV_W'(TEST_HEIGHT_INC - 1);
            end else if (line_end) begin
                row_q <= row_q + 1'b1;
                if (row_div_q == '0) begin
                    row_div_q <= RDIV_W'(TEST_HEIGHT_INC - 1);
                    row8_q    <= row8_q + 1'b1;
                end else begin
                    row_div_q <= row_div_q - 1'b1;
                end
            end
        end
    end

    // gradient select, values zero-extended
    always_comb begin
        case (test_mode_i)
            test_mode_t'(0): pxd_o = pxd_i;                 // real pixels
            test_mode_t'(1): pxd_o = {row8_q, col8_q};
            test_mode_t'(2): pxd_o = pix_t'(col_q);
            default:         pxd_o = pix_t'(row_q);
        endcase
    end

    // every line starts from column 0
    a_col_start: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        (dvalid_i && !dvalid_q) |-> (col_q == '0));

endmodule

`default_nettype wire

// File: src/sens_ctrl_regs.sv
/*
 * Sensor control registers. Latches a write from the command receiver,
 * then updates each control field only when its set bit is 1. Also
 * produces clear pulses for the status monitor sticky flags.
 */
`timescale 1ns/1ns
`default_nettype none

module sens_ctrl_regs (
    input  wire logic                   pclk,
    input  wire logic                   async_prst_with_sens_mrst,
    input  wire logic                   cmd_we_i,
    input  wire sens_io_pkg::cmd_addr_t cmd_a_i,
    input  wire sens_io_pkg::cmd_data_t cmd_data_i,
    output logic                        imrst_o,
    output logic [3:0]                  gp_oe_o,
    output logic [3:0]                  gp_out_o,
    output logic                        alt_status_o,
    output sens_io_pkg::test_mode_t     test_mode_o,
    output logic                        clr_perr_o,
    output logic                        clr_hact_o
);
    import sens_io_pkg::*;

    localparam int unsigned GP_POS [4] = '{CTRL_GP0, CTRL_GP1, CTRL_GP2, CTRL_GP3};

    cmd_data_t      data_q;         // write data, one cycle after cmd_we
    logic           set_ctrl_q;
    logic           set_status_q;
    gp_mode_t [3:0] gp_q;           // per pin mode

    always_ff @(posedge pclk) begin
        if (cmd_we_i) data_q <= cmd_data_i;
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            set_ctrl_q   <= 1'b0;
            set_status_q <= 1'b0;
            imrst_o      <= 1'b0;
            gp_q         <= '0;     // all pins float
            alt_status_o <= 1'b0;
            test_mode_o  <= '0;
        end else begin
            set_ctrl_q   <= cmd_we_i && (cmd_a_i == cmd_addr_t'(SENSIO_CTRL));
            set_status_q <= cmd_we_i && (cmd_a_i == cmd_addr_t'(SENSIO_STATUS));

            if (set_ctrl_q && data_q[CTRL_MRST_SET])       imrst_o <= data_q[CTRL_MRST];
            for (int i = 0; i < 4; i++) begin
                if (set_ctrl_q && data_q[GP_POS[i] + 2])  gp_q[i] <= data_q[GP_POS[i] +: 2];
            end
            if (set_ctrl_q && data_q[CTRL_ALT_STATUS_SET]) alt_status_o <= data_q[CTRL_ALT_STATUS];
            if (set_ctrl_q && data_q[CTRL_TEST_SET])
                test_mode_o <= data_q[CTRL_TEST_MODE +: TEST_BITS];
        end
    end

    // mode to pin driver, trigger mode drives high for now
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            gp_oe_o[i]  = |gp_q[i];     // any nonzero mode drives
            gp_out_o[i] = gp_q[i][1];   // level is mode msb
        end
    end

    assign clr_perr_o = set_ctrl_q;     // every control write
    assign clr_hact_o = set_status_q;   // every status control write

    a_clr_exclusive: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        !(clr_perr_o && clr_hact_o));

endmodule

`default_nettype wire

// File: src/cmd_deser.sv
/*
 * Byte-serial command receiver. Collects six bytes started by cmd_stb_i
 * (address low/high, then four data bytes LSB first) and issues a single
 * cycle write when the 16-bit address falls into the base/mask window.
 */
`timescale 1ns/1ns
`default_nettype none

module cmd_deser #(
    parameter logic [15:0] SENSIO_ADDR      = 16'h330,
    parameter logic [15:0] SENSIO_ADDR_MASK = 16'h7f8
) (
    input  wire logic                   pclk,
    input  wire logic                   async_prst_with_sens_mrst,
    input  wire logic [7:0]             cmd_ad_i,
    input  wire logic                   cmd_stb_i,
    output sens_io_pkg::cmd_addr_t      cmd_a_o,
    output sens_io_pkg::cmd_data_t      cmd_data_o,
    output logic                        cmd_we_o
);
    import sens_io_pkg::*;

    localparam int unsigned CNT_W = $clog2(CMD_BYTES);

    logic [CNT_W-1:0]       cnt_q;      // 0 - idle, else next byte index
    logic [CMD_BYTES*8-1:0] sr_q;       // shifted in from the top
    logic                   full_q;     // sixth byte just landed in sr_q
    logic                   busy;

    assign busy = cmd_stb_i || (cnt_q != '0);

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            cnt_q    <= '0;
            full_q   <= 1'b0;
            cmd_we_o <= 1'b0;
        end else begin
            full_q <= !cmd_stb_i && (cnt_q == CNT_W'(CMD_BYTES - 1));
            if (cmd_stb_i)                             cnt_q <= CNT_W'(1); // restart on any strobe
            else if (cnt_q == CNT_W'(CMD_BYTES - 1))   cnt_q <= '0;
            else if (cnt_q != '0)                      cnt_q <= cnt_q + 1'b1;
            cmd_we_o <= full_q &&
                ((sr_q[15:0] & SENSIO_ADDR_MASK) == (SENSIO_ADDR & SENSIO_ADDR_MASK));
        end
    end

    // payload path
    always_ff @(posedge pclk) begin
        if (busy) sr_q <= {cmd_ad_i, sr_q[CMD_BYTES*8-1:8]};  // byte 0 ends up lowest
        if (full_q) begin
            cmd_a_o    <= sr_q[$bits(cmd_addr_t)-1:0];        // low address bits only
            cmd_data_o <= sr_q[16 +: $bits(cmd_data_t)];
        end
    end

    // a write needs a strobe seven cycles back and five more bytes without restart
    a_we_after_full: assert property (@(posedge pclk) disable iff (async_prst_with_sens_mrst)
        $rose(cmd_we_o) |-> $past(cmd_stb_i, CMD_BYTES + 1) &&
            !$past(cmd_stb_i, 2) && !$past(cmd_stb_i, 3) && !$past(cmd_stb_i, 4) &&
            !$past(cmd_stb_i, 5) && !$past(cmd_stb_i, 6));

endmodule

`default_nettype wire

// File: src/sens_io_pkg.sv
/*
 * Shared definitions for the sensor front-end port: command addresses,
 * control register field positions, pixel and status widths and the
 * status word layout. Imported by every RTL block of the port.
 */
`default_nettype none

package sens_io_pkg;

    localparam int unsigned TEST_BITS = 3;      // test mode field width

    typedef logic [2:0]           cmd_addr_t;   // local register address
    typedef logic [31:0]          cmd_data_t;   // command payload
    typedef logic [15:0]          pix_t;        // pixel word
    typedef logic [15:0]          status_t;     // parallel status word
    typedef logic [TEST_BITS-1:0] test_mode_t;  // 0 pass, 1 row8/col8, 2 col, 3+ row
    typedef logic [1:0]           gp_mode_t;    // 00 float, 01 low, 10 high, 11 trigger

    // command framing
    localparam int unsigned CMD_BYTES     = 6;  // AL, AH, D0..D3
    localparam int unsigned SENSIO_CTRL   = 0;
    localparam int unsigned SENSIO_STATUS = 1;

    // control register fields, value bit(s) followed by a set bit
    localparam int unsigned CTRL_MRST           = 0;
    localparam int unsigned CTRL_MRST_SET       = 1;
    localparam int unsigned CTRL_GP0            = 12;  // set bit at +2
    localparam int unsigned CTRL_GP1            = 15;
    localparam int unsigned CTRL_GP2            = 18;
    localparam int unsigned CTRL_GP3            = 21;
    localparam int unsigned CTRL_ALT_STATUS     = 24;
    localparam int unsigned CTRL_ALT_STATUS_SET = 25;
    localparam int unsigned CTRL_TEST_MODE      = 26;  // 28:26
    localparam int unsigned CTRL_TEST_SET       = 29;

    // test gradient counter widths
    localparam int unsigned COL_BITS = 10;
    localparam int unsigned ROW_BITS = 10;

    // status word layout
    localparam int unsigned ST_BYTE        = 0;   // 7:0, perr count in alt mode
    localparam int unsigned ST_PERR_STICKY = 8;
    localparam int unsigned ST_HACT_ALIVE  = 9;
    localparam int unsigned ST_SENS_MRST   = 10;
    localparam int unsigned ST_TEST_ACTIVE = 11;
    localparam int unsigned ST_GP_IN       = 12;  // 15:12 pin levels

endpackage

`default_nettype wire
